/* design/gnn_agg_pkg.sv */
// shared widths, element typedefs and packet structs for the edge aggregation stage; import where needed
`default_nettype none

package gnn_agg_pkg;

    // element and id widths
    localparam int FV_ELEM_W = 8;
    localparam int NODE_ID_W = 6;
    localparam int OUT_DATA_W = 2 * FV_ELEM_W;

    typedef logic [FV_ELEM_W-1:0] fv_elem_t;
    typedef logic [NODE_ID_W-1:0] node_id_t;
    typedef logic [OUT_DATA_W-1:0] out_data_t;

    // two elements per beat, index 0 is the even element
    typedef fv_elem_t [1:0] fv_pair_t;

    // one beat from an edge PE, or a single-beat command
    typedef struct packed {
        logic     sos;
        logic     eos;
        logic     wb_en;
        logic     done_aggr;
        node_id_t node_id;
        fv_pair_t fv_data;
    } edge_pkt_t;

    // one beat toward the reservation station
    typedef struct packed {
        logic     sos;
        logic     eos;
        node_id_t node_id;
        fv_pair_t fv_data;
    } rs_pkt_t;

    // one beat toward the output buffer
    // data holds the even element in the low byte, the odd one in the high byte
    typedef struct packed {
        logic      req;
        logic      grant_valid;
        logic      sos;
        logic      eos;
        node_id_t  node_id;
        out_data_t data;
    } out_pkt_t;

endpackage

`default_nettype wire

/* design/edge_dispatch.sv */
// steers each incoming edge beat or command to its accumulation bank, one cycle of latency
`timescale 1ns/1ps
`default_nettype none

module edge_dispatch #(
    parameter int NUM_BANKS = 2,
    localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire gnn_agg_pkg::edge_pkt_t                in,
    output gnn_agg_pkg::edge_pkt_t [NUM_BANKS-1:0]     bank_pkt
);
    import gnn_agg_pkg::*;

    logic              stream_open;
    logic [BANK_W-1:0] open_bank;
    logic [BANK_W-1:0] node_bank;
    logic [BANK_W-1:0] sel;
    logic              beat_valid;

    // low node id bits pick the bank
    assign node_bank = BANK_W'(in.node_id & node_id_t'(NUM_BANKS - 1));

    // beats inside an open stream follow the bank chosen at sos
    assign sel = (stream_open && !in.sos) ? open_bank : node_bank;

    assign beat_valid = in.sos | stream_open | in.wb_en | in.done_aggr;

    always_ff @(posedge clk) begin
        if (reset) begin
            stream_open <= 1'b0;
            open_bank   <= '0;
        end else if (in.sos) begin
            // a one-beat stream never opens
            stream_open <= !in.eos;
            open_bank   <= node_bank;
        end else if (stream_open && in.eos) begin
            stream_open <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_pkt <= '0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_pkt[b] <= (beat_valid && sel == BANK_W'(b)) ? in : '0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/rr_grant_arbiter.sv */
// round-robin port arbiter: one grant pulse per stream, port locked until the owner's eos
`timescale 1ns/1ps
`default_nettype none

module rr_grant_arbiter #(
    parameter int NUM_BANKS = 2,
    localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [NUM_BANKS-1:0] req,
    input  wire logic                 sink_ready,
    input  wire logic [NUM_BANKS-1:0] stream_eos,
    output logic      [NUM_BANKS-1:0] grant,
    output logic      [BANK_W-1:0]    owner,
    output logic                      owned
);

    logic [BANK_W-1:0] ptr;
    logic [BANK_W-1:0] owner_q;
    logic [BANK_W-1:0] pick;
    logic [BANK_W-1:0] idx;
    logic              found;
    logic              lock;
    logic              grant_any;

    // search starts one past the last winner
    always_comb begin
        pick  = ptr;
        found = 1'b0;
        idx   = '0;
        for (int i = 1; i <= NUM_BANKS; i++) begin
            idx = BANK_W'((int'(ptr) + i) % NUM_BANKS);
            if (!found && req[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (!lock && sink_ready && found) begin
            grant[pick] = 1'b1;
        end
    end

    assign grant_any = |grant;

    // owned already in the grant cycle so beat 0 reaches the port
    assign owned = lock | grant_any;
    assign owner = lock ? owner_q : pick;

    always_ff @(posedge clk) begin
        if (reset) begin
            lock    <= 1'b0;
            owner_q <= '0;
            ptr     <= BANK_W'(NUM_BANKS - 1);
        end else if (grant_any) begin
            owner_q <= pick;
            ptr     <= pick;
            // one-beat stream ends in its own grant cycle
            lock    <= !stream_eos[pick];
        end else if (lock && stream_eos[owner_q]) begin
            lock <= 1'b0;
        end
    end

    // while the port is locked only the owner may end a stream
    eos_only_from_owner: assert property (
        @(posedge clk) disable iff (reset)
        lock |-> ((stream_eos & ~(NUM_BANKS'(1) << owner_q)) == '0)
    );

endmodule

`default_nettype wire

/* design/edge_bank.sv */
// one accumulation bank: sums edge streams for a node and drains to the output buffer or RS
`timescale 1ns/1ps
`default_nettype none

module edge_bank #(
    parameter int MAX_FV_NUM = 8
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire gnn_agg_pkg::edge_pkt_t edge_pkt,
    input  wire logic                   out_grant,
    input  wire logic                   rs_grant,
    output logic                        rs_req,
    output gnn_agg_pkg::rs_pkt_t        rs_pkt,
    output logic                        busy,
    output gnn_agg_pkg::out_pkt_t       out_pkt
);
    import gnn_agg_pkg::*;

    localparam int NUM_BEATS = MAX_FV_NUM / 2;
    localparam int BEAT_W = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

    typedef enum logic [2:0] {
        idle,
        stream_in,
        complete,
        out_rs_wait,
        out_rs,
        out_fv_wait,
        out_fv
    } state_t;

    state_t state;

    // summed vector, one element pair per beat
    fv_pair_t [NUM_BEATS-1:0] buffer;

    logic [BEAT_W-1:0] beat;
    logic [BEAT_W:0]   vec_len;
    logic              len_valid;
    node_id_t          cur_node;

    logic accept_sos;
    logic accept_beat;
    logic out_active;
    logic drain_go;
    logic drain_rs;
    logic last_beat;

    assign busy = (state != idle);

    // a new stream can start from idle or on top of a finished sum
    assign accept_sos = edge_pkt.sos && (state == idle || state == complete);

    // streams are never stalled, so every cycle in stream_in carries a beat
    assign accept_beat = accept_sos || (state == stream_in);

    assign last_beat = (({1'b0, beat} + 1'b1) == vec_len);

    assign out_active = (state == out_fv_wait && out_grant) || (state == out_fv);
    assign drain_rs = (state == out_rs_wait && rs_grant) || (state == out_rs);
    assign drain_go = out_active || drain_rs;

    assign rs_req = (state == out_rs_wait);

    // output buffer beats leave combinationally, beat 0 in the grant cycle
    always_comb begin
        out_pkt = '0;
        out_pkt.node_id = cur_node;
        out_pkt.req = (state == out_fv_wait);
        if (out_active) begin
            out_pkt.grant_valid = 1'b1;
            out_pkt.sos = (state == out_fv_wait);
            out_pkt.eos = last_beat;
            out_pkt.data = {buffer[beat][1], buffer[beat][0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= idle;
            beat      <= '0;
            vec_len   <= '0;
            len_valid <= 1'b0;
            cur_node  <= '0;
            buffer    <= '0;
            rs_pkt    <= '0;
        end else begin
            // rs port idles at zero between drains
            rs_pkt <= '0;

            if (accept_beat) begin
                // element-wise add, wraps modulo 256
                buffer[beat][0] <= buffer[beat][0] + edge_pkt.fv_data[0];
                buffer[beat][1] <= buffer[beat][1] + edge_pkt.fv_data[1];
                if (accept_sos) begin
                    cur_node <= edge_pkt.node_id;
                end
                if (edge_pkt.eos) begin
                    beat  <= '0;
                    state <= complete;
                    // later streams reuse the first stream's length
                    if (!len_valid) begin
                        vec_len   <= {1'b0, beat} + 1'b1;
                        len_valid <= 1'b1;
                    end
                end else begin
                    beat  <= beat + 1'b1;
                    state <= stream_in;
                end
            end else if (drain_go) begin
                if (drain_rs) begin
                    rs_pkt.sos     <= (state == out_rs_wait);
                    rs_pkt.eos     <= last_beat;
                    rs_pkt.node_id <= cur_node;
                    rs_pkt.fv_data <= buffer[beat];
                end
                if (last_beat) begin
                    // next job starts from a clean buffer
                    state     <= idle;
                    beat      <= '0;
                    buffer    <= '0;
                    len_valid <= 1'b0;
                end else begin
                    beat  <= beat + 1'b1;
                    state <= drain_rs ? out_rs : out_fv;
                end
            end else if (state == complete) begin
                if (edge_pkt.done_aggr) begin
                    state <= out_rs_wait;
                end else if (edge_pkt.wb_en) begin
                    state <= out_fv_wait;
                end
            end
        end
    end

    // dispatch must not open a stream into a bank that is draining
    sos_while_draining: assert property (
        @(posedge clk) disable iff (reset)
        (state inside {out_rs_wait, out_rs, out_fv_wait, out_fv}) |-> !edge_pkt.sos
    );

endmodule

`default_nettype wire

/* design/edge_agg_top.sv */
// edge aggregation stage top: dispatch, accumulation banks, two port arbiters and output muxes
`timescale 1ns/1ps
`default_nettype none

module edge_agg_top #(
    parameter int NUM_BANKS = 2,
    parameter int MAX_FV_NUM = 8,
    localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire gnn_agg_pkg::edge_pkt_t in,
    input  wire logic                   out_grant,
    input  wire logic                   rs_grant,
    output gnn_agg_pkg::out_pkt_t       out,
    output gnn_agg_pkg::rs_pkt_t        rs,
    output logic [NUM_BANKS-1:0]        bank_busy
);
    import gnn_agg_pkg::*;

    edge_pkt_t [NUM_BANKS-1:0] bank_pkt;
    out_pkt_t  [NUM_BANKS-1:0] bank_out;
    rs_pkt_t   [NUM_BANKS-1:0] bank_rs;

    logic [NUM_BANKS-1:0] out_req;
    logic [NUM_BANKS-1:0] out_eos;
    logic [NUM_BANKS-1:0] out_gnt;
    logic [NUM_BANKS-1:0] rs_req;
    logic [NUM_BANKS-1:0] rs_eos;
    logic [NUM_BANKS-1:0] rs_gnt;

    logic [BANK_W-1:0] out_owner;
    logic [BANK_W-1:0] rs_owner;
    logic              out_owned;
    logic              rs_owned;

    edge_dispatch #(
        .NUM_BANKS (NUM_BANKS)
    ) u_dispatch (
        .clk      (clk),
        .reset    (reset),
        .in       (in),
        .bank_pkt (bank_pkt)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        edge_bank #(
            .MAX_FV_NUM (MAX_FV_NUM)
        ) u_bank (
            .clk       (clk),
            .reset     (reset),
            .edge_pkt  (bank_pkt[b]),
            .out_grant (out_gnt[b]),
            .rs_grant  (rs_gnt[b]),
            .rs_req    (rs_req[b]),
            .rs_pkt    (bank_rs[b]),
            .busy      (bank_busy[b]),
            .out_pkt   (bank_out[b])
        );

        assign out_req[b] = bank_out[b].req;
        assign out_eos[b] = bank_out[b].eos;
        assign rs_eos[b]  = bank_rs[b].eos;
    end

    // output buffer port
    rr_grant_arbiter #(
        .NUM_BANKS (NUM_BANKS)
    ) u_out_arb (
        .clk        (clk),
        .reset      (reset),
        .req        (out_req),
        .sink_ready (out_grant),
        .stream_eos (out_eos),
        .grant      (out_gnt),
        .owner      (out_owner),
        .owned      (out_owned)
    );

    // reservation station port
    rr_grant_arbiter #(
        .NUM_BANKS (NUM_BANKS)
    ) u_rs_arb (
        .clk        (clk),
        .reset      (reset),
        .req        (rs_req),
        .sink_ready (rs_grant),
        .stream_eos (rs_eos),
        .grant      (rs_gnt),
        .owner      (rs_owner),
        .owned      (rs_owned)
    );

    // free port only shows the pending requests
    always_comb begin
        out = '0;
        if (out_owned) begin
            out = bank_out[out_owner];
        end else begin
            out.req = |out_req;
        end
    end

    assign rs = rs_owned ? bank_rs[rs_owner] : '0;

endmodule

`default_nettype wire

/* test/tb_edge_agg.sv */
// table-driven testbench for edge_agg_top: drives edge streams and drain commands, checks out and rs
`timescale 1ns/1ps
`default_nettype none

module tb_edge_agg;
    import gnn_agg_pkg::*;

    localparam int NUM_BANKS = 2;
    localparam int MAX_FV_NUM = 8;
    localparam int NUM_BEATS = MAX_FV_NUM / 2;
    localparam int NUM_CASES = 10;

    typedef struct packed {
        node_id_t   node;
        logic [3:0] streams;
        logic       rnd;
        fv_elem_t   base;
        logic       done;
        logic       pair;
    } case_t;

    // node, streams, random values, fixed base, done (else write-back), drained with next entry
    // the two pairs are set up so the round-robin order flips between them
    localparam case_t CASES [NUM_CASES] = '{
        '{6'd6,  4'd1, 1'b0, 8'h10, 1'b0, 1'b0},
        '{6'd9,  4'd3, 1'b1, 8'h00, 1'b1, 1'b0},
        '{6'd9,  4'd2, 1'b0, 8'hf0, 1'b1, 1'b0},
        '{6'd6,  4'd1, 1'b1, 8'h00, 1'b0, 1'b0},
        '{6'd12, 4'd2, 1'b1, 8'h00, 1'b0, 1'b1},
        '{6'd21, 4'd1, 1'b1, 8'h00, 1'b0, 1'b0},
        '{6'd21, 4'd1, 1'b0, 8'h3c, 1'b0, 1'b0},
        '{6'd4,  4'd1, 1'b1, 8'h00, 1'b0, 1'b1},
        '{6'd33, 4'd2, 1'b1, 8'h00, 1'b0, 1'b0},
        '{6'd14, 4'd2, 1'b0, 8'h81, 1'b1, 1'b0}
    };

    logic                 clk;
    logic                 reset;
    edge_pkt_t            edge_in;
    logic                 out_grant;
    logic                 rs_grant;
    out_pkt_t             out;
    rs_pkt_t              rs;
    logic [NUM_BANKS-1:0] bank_busy;

    int seed = 32'h0c0551a1;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;
    int out_last;

    // reference sums per node, wrapping at 8 bits
    fv_elem_t  exp_sum [2**NODE_ID_W][MAX_FV_NUM];
    node_id_t  out_node_q [$];
    node_id_t  rs_node_q [$];
    out_data_t out_data_q [$];
    out_data_t rs_data_q [$];

    // monitor state, port 0 is out and port 1 is rs
    logic      open_s [2];
    int        cnt [2];
    node_id_t  got_node [2];
    out_data_t got_data [2][NUM_BEATS];

    edge_agg_top #(
        .NUM_BANKS  (NUM_BANKS),
        .MAX_FV_NUM (MAX_FV_NUM)
    ) DUT (
        .clk       (clk),
        .reset     (reset),
        .in        (edge_in),
        .out_grant (out_grant),
        .rs_grant  (rs_grant),
        .out       (out),
        .rs        (rs),
        .bank_busy (bank_busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("checks: %0d errors: %0d", checks, errors + 1);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic int bank_of(input node_id_t node);
        return int'(node) % NUM_BANKS;
    endfunction

    function automatic string port_name(input int port);
        return (port == 1) ? "rs" : "out";
    endfunction

    task automatic drive(input edge_pkt_t p);
        @(posedge clk);
        edge_in <= p;
    endtask

    task automatic set_out_grant(input logic v);
        @(posedge clk);
        out_grant <= v;
    endtask

    task automatic send_streams(input case_t c);
        fv_elem_t    vals [MAX_FV_NUM];
        edge_pkt_t   p;
        logic [31:0] r;
        for (int s = 0; s < int'(c.streams); s++) begin
            for (int e = 0; e < MAX_FV_NUM; e++) begin
                if (c.rnd) begin
                    r = $random(seed);
                    vals[e] = r[7:0];
                end else begin
                    vals[e] = c.base + fv_elem_t'(e);
                end
                exp_sum[c.node][e] = exp_sum[c.node][e] + vals[e];
            end
            for (int b = 0; b < NUM_BEATS; b++) begin
                p = '0;
                p.sos = (b == 0);
                p.eos = (b == NUM_BEATS - 1);
                p.node_id = c.node;
                p.fv_data[0] = vals[2*b];
                p.fv_data[1] = vals[2*b+1];
                drive(p);
            end
        end
    endtask

    task automatic send_cmd(input case_t c);
        edge_pkt_t p;
        p = '0;
        p.node_id = c.node;
        if (c.done) begin
            p.done_aggr = 1'b1;
        end else begin
            p.wb_en = 1'b1;
        end
        drive(p);
    endtask

    // moves a node's reference sum into the expected stream queue of its port
    task automatic push_expect(input node_id_t node, input logic done);
        out_data_t w;
        for (int b = 0; b < NUM_BEATS; b++) begin
            // even element in the low byte
            w = {exp_sum[node][2*b+1], exp_sum[node][2*b]};
            if (done) begin
                rs_data_q.push_back(w);
            end else begin
                out_data_q.push_back(w);
            end
        end
        for (int e = 0; e < MAX_FV_NUM; e++) begin
            exp_sum[node][e] = '0;
        end
        if (done) begin
            rs_node_q.push_back(node);
        end else begin
            out_node_q.push_back(node);
            out_last = bank_of(node);
        end
    endtask

    task automatic close_stream(input int port);
        node_id_t  exp_node;
        out_data_t exp_w;
        string     sig;
        sig = (port == 1) ? "rs.fv_data" : "out.data";
        if ((port == 1 && rs_node_q.size() == 0) || (port == 0 && out_node_q.size() == 0)) begin
            $display("%0t: unexpected stream on the %s port for node %0d",
                     $time, port_name(port), got_node[port]);
            errors++;
        end else begin
            if (port == 1) begin
                exp_node = rs_node_q.pop_front();
            end else begin
                exp_node = out_node_q.pop_front();
            end
            checks++;
            if (got_node[port] !== exp_node) begin
                $display("** Error at %0t: %s.node_id expected %0d got %0d",
                         $time, port_name(port), exp_node, got_node[port]);
                errors++;
            end
            if (cnt[port] != NUM_BEATS) begin
                $display("** Error at %0t: %s beat count expected %0d got %0d",
                         $time, port_name(port), NUM_BEATS, cnt[port]);
                errors++;
            end
            for (int b = 0; b < NUM_BEATS; b++) begin
                if (port == 1) begin
                    exp_w = rs_data_q.pop_front();
                end else begin
                    exp_w = out_data_q.pop_front();
                end
                if (b < cnt[port] && got_data[port][b] !== exp_w) begin
                    $display("** Error at %0t: %s beat %0d expected %h got %h",
                             $time, sig, b, exp_w, got_data[port][b]);
                    errors++;
                end
            end
        end
    endtask

    // gathers beats between sos and eos on one port
    task automatic watch(input int port, input logic sos, input logic eos, input logic valid,
                         input node_id_t nid, input out_data_t data);
        if (sos) begin
            if (open_s[port]) begin
                $display("%0t: new stream on the %s port before the last one ended",
                         $time, port_name(port));
                errors++;
            end
            open_s[port] = 1'b1;
            cnt[port] = 0;
            got_node[port] = nid;
        end
        if (open_s[port]) begin
            if (port == 0 && !valid) begin
                $display("%0t: out beat inside a stream without grant_valid", $time);
                errors++;
            end
            if (cnt[port] < NUM_BEATS) begin
                got_data[port][cnt[port]] = data;
            end
            cnt[port]++;
            if (eos) begin
                open_s[port] = 1'b0;
                close_stream(port);
            end
        end else if (valid || eos) begin
            $display("%0t: beat outside any stream on the %s port", $time, port_name(port));
            errors++;
        end
    endtask

    // rs has no valid bit, so only a stray eos shows up there
    always @(negedge clk) begin
        if (!reset) begin
            watch(0, out.sos, out.eos, out.grant_valid, out.node_id, out.data);
            watch(1, rs.sos, rs.eos, 1'b0, rs.node_id, rs.fv_data);
        end
    end

    task automatic wait_drained();
        @(negedge clk);
        while (out_node_q.size() != 0 || rs_node_q.size() != 0 || open_s[0] || open_s[1]) begin
            @(negedge clk);
        end
    endtask

    // two banks request write-back together while out_grant is low
    task automatic run_pair(input case_t a, input case_t b);
        int                   idx;
        logic                 found;
        logic                 a_first;
        logic [NUM_BANKS-1:0] mask;
        send_cmd(a);
        send_cmd(b);
        drive('0);
        // winner is the first requester after the previous winner
        found = 1'b0;
        a_first = 1'b0;
        for (int i = 1; i <= NUM_BANKS; i++) begin
            idx = (out_last + i) % NUM_BANKS;
            if (!found && idx == bank_of(a.node)) begin
                a_first = 1'b1;
                found = 1'b1;
            end else if (!found && idx == bank_of(b.node)) begin
                found = 1'b1;
            end
        end
        if (a_first) begin
            push_expect(a.node, a.done);
            push_expect(b.node, b.done);
        end else begin
            push_expect(b.node, b.done);
            push_expect(a.node, a.done);
        end
        mask = '0;
        mask[bank_of(a.node)] = 1'b1;
        mask[bank_of(b.node)] = 1'b1;
        repeat (8) begin
            @(negedge clk);
            checks++;
            if (out.grant_valid) begin
                $display("%0t: out stream appeared while out_grant was low", $time);
                errors++;
            end
            // a free port still shows the pending requests
            if (out.req !== 1'b1) begin
                $display("** Error at %0t: out.req expected 1 got %b", $time, out.req);
                errors++;
            end
            if ((bank_busy & mask) != mask) begin
                $display("** Error at %0t: bank_busy expected %b got %b", $time, mask, bank_busy);
                errors++;
            end
        end
        set_out_grant(1'b1);
        wait_drained();
    endtask

    initial begin
        case_t c;
        case_t held;
        logic  held_valid;
        int    total;
        edge_in = '0;
        out_grant = 1'b1;
        rs_grant = 1'b1;
        reset = 1'b1;
        out_last = NUM_BANKS - 1;
        held = '0;
        held_valid = 1'b0;
        total = 0;
        for (int n = 0; n < 2**NODE_ID_W; n++) begin
            for (int e = 0; e < MAX_FV_NUM; e++) begin
                exp_sum[n][e] = '0;
            end
        end
        open_s[0] = 1'b0;
        open_s[1] = 1'b0;
        // stream beats, command and drain of every entry
        for (int i = 0; i < NUM_CASES; i++) begin
            total += int'(CASES[i].streams) * NUM_BEATS + 1 + NUM_BEATS;
        end
        limit = total * 4 + 200;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checks++;
        if ({out.req, out.sos, out.eos, out.grant_valid} !== 4'b0) begin
            $display("** Error at %0t: out.req/sos/eos/grant_valid expected 0000 got %b",
                     $time, {out.req, out.sos, out.eos, out.grant_valid});
            errors++;
        end
        if ({rs.sos, rs.eos} !== 2'b0) begin
            $display("** Error at %0t: rs.sos/eos expected 00 got %b", $time, {rs.sos, rs.eos});
            errors++;
        end
        if (bank_busy !== '0) begin
            $display("** Error at %0t: bank_busy expected 0 got %b", $time, bank_busy);
            errors++;
        end

        for (int i = 0; i < NUM_CASES; i++) begin
            c = CASES[i];
            if (c.pair && !held_valid) begin
                set_out_grant(1'b0);
            end
            send_streams(c);
            if (c.pair) begin
                held = c;
                held_valid = 1'b1;
            end else if (held_valid) begin
                run_pair(held, c);
                held_valid = 1'b0;
            end else begin
                send_cmd(c);
                drive('0);
                push_expect(c.node, c.done);
                wait_drained();
            end
        end

        repeat (4) @(negedge clk);
        checks++;
        if (bank_busy != '0) begin
            $display("%0t: bank_busy stuck high at the end of the run: %b", $time, bank_busy);
            errors++;
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* gnn_edge_agg.f */
design/gnn_agg_pkg.sv
design/edge_dispatch.sv
design/rr_grant_arbiter.sv
design/edge_bank.sv
design/edge_agg_top.sv
test/tb_edge_agg.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_edge_agg \
    -Mdir obj_dir \
    -f gnn_edge_agg.f

./obj_dir/Vtb_edge_agg 2>&1 | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
